/* hw/tcdm_pkg.sv */
package tcdm_pkg;

  // width of one memory word
  localparam int unsigned DATA_W = 32;
  // requesters drive a full word address and the bank keeps only the low bits it needs
  localparam int unsigned ADDR_W = 16;
  // enough id bits for up to 16 requester ports
  localparam int unsigned ID_W = 4;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [ID_W-1:0]   port_id_t;

  // command held stable by one requester while its req is high
  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
  } mem_cmd_t;

  // the winning command as seen by the bank, tagged with the winner's port id
  typedef struct packed {
    logic     valid;
    logic     we;
    addr_t    addr;
    data_t    wdata;
    port_id_t id;
  } bank_req_t;

  // read response, broadcast to every requester
  // each port keeps it only when id matches its own index
  typedef struct packed {
    logic     valid;
    port_id_t id;
    data_t    rdata;
  } mem_rsp_t;

endpackage : tcdm_pkg

/* hw/lzc.sv */
// counts zeros from one end of the input vector
// with MODE 0 it counts trailing zeros from the lsb, with MODE 1 leading zeros from the msb
module lzc #(
  parameter int unsigned WIDTH = 2,
  parameter int unsigned MODE  = 0,
  localparam int unsigned CNT_W = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
  input  logic [WIDTH-1:0] in,
  output logic [CNT_W-1:0] cnt,
  output logic             empty
);

  // depth of the select tree, one level per count bit
  localparam int unsigned LEVELS = $clog2(WIDTH);

  // a zero-width counter has no meaning, stop elaboration
  if (WIDTH == 0) begin : g_width_check
    $fatal(1, "lzc: WIDTH must be at least one bit");
  end

  // the tree always searches from bit 0, so leading mode mirrors the input first
  logic [WIDTH-1:0] vec;

  for (genvar i = 0; i < WIDTH; i++) begin : g_flip
    assign vec[i] = (MODE != 0) ? in[WIDTH-1-i] : in[i];
  end

  if (LEVELS == 0) begin : g_single_bit
    // one input bit has only index zero
    assign cnt   = '0;
    assign empty = ~vec[0];
  end else begin : g_tree
    // nodes are stored heap style, node n has children 2n+1 and 2n+2
    localparam int unsigned NODES = 2 ** LEVELS - 1;

    // node_sel says some bit below this node is set
    logic [NODES-1:0]             node_sel;
    // node_idx is the lowest set bit index below this node
    logic [NODES-1:0][LEVELS-1:0] node_idx;

    for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : g_lvl
      for (genvar k = 0; k < 2 ** lvl; k++) begin : g_node
        localparam int unsigned N = 2 ** lvl - 1 + k;

        if (lvl == LEVELS - 1) begin : g_leaf
          // bottom nodes each cover two input bits
          localparam int unsigned LO = 2 * k;

          if (LO + 1 < WIDTH) begin : g_pair
            assign node_sel[N] = vec[LO] | vec[LO+1];
            // the lower bit wins when both are set
            assign node_idx[N] = vec[LO] ? LEVELS'(LO) : LEVELS'(LO + 1);
          end else if (LO < WIDTH) begin : g_odd
            // odd width leaves the last leaf with only one real bit
            assign node_sel[N] = vec[LO];
            assign node_idx[N] = LEVELS'(LO);
          end else begin : g_pad
            // padding leaves beyond the input never select
            assign node_sel[N] = 1'b0;
            assign node_idx[N] = '0;
          end
        end else begin : g_inner
          localparam int unsigned C = 2 * N + 1;

          // prefer the left child, it covers the lower bit indices
          assign node_sel[N] = node_sel[C] | node_sel[C+1];
          assign node_idx[N] = node_sel[C] ? node_idx[C] : node_idx[C+1];
        end
      end
    end

    // the root holds the answer for the whole vector
    assign cnt   = node_idx[0];
    assign empty = ~node_sel[0];
  end

endmodule : lzc

/* hw/rr_arbiter.sv */
// round-robin arbiter in front of the single-port bank
// grant is combinational, the priority pointer moves one past the winner after each grant
module rr_arbiter #(
  parameter int unsigned NUM_PORTS = 4
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [NUM_PORTS-1:0]                 req,
  input  tcdm_pkg::mem_cmd_t [NUM_PORTS-1:0]   cmd,
  output logic [NUM_PORTS-1:0]                 gnt,
  output tcdm_pkg::bank_req_t                  bank_req
);

  localparam int unsigned IDX_W = $clog2(NUM_PORTS);

  // port with the highest priority in the current cycle
  logic [IDX_W-1:0]     ptr;
  logic [IDX_W-1:0]     ptr_next;

  // thermometer mask of ports at or above the pointer
  logic [NUM_PORTS-1:0] mask;
  logic [NUM_PORTS-1:0] req_masked;

  logic [IDX_W-1:0]     idx_masked;
  logic [IDX_W-1:0]     idx_all;
  logic                 empty_masked;
  logic                 empty_all;
  logic [IDX_W-1:0]     winner;

  assign mask       = {NUM_PORTS{1'b1}} << ptr;
  assign req_masked = req & mask;

  // first requester at or above the pointer
  lzc #(
    .WIDTH (NUM_PORTS),
    .MODE  (0)
  ) u_lzc_masked (
    .in    (req_masked),
    .cnt   (idx_masked),
    .empty (empty_masked)
  );

  // first requester overall, used when nobody at or above the pointer asks,
  // which is the wrap-around case
  lzc #(
    .WIDTH (NUM_PORTS),
    .MODE  (0)
  ) u_lzc_all (
    .in    (req),
    .cnt   (idx_all),
    .empty (empty_all)
  );

  assign winner = empty_masked ? idx_all : idx_masked;

  // one-hot grant, all zero when no port requests
  assign gnt = empty_all ? '0 : (NUM_PORTS'(1) << winner);

  // the winner's command goes to the bank together with its port id
  always_comb begin
    bank_req.valid = |gnt;
    bank_req.we    = cmd[winner].we;
    bank_req.addr  = cmd[winner].addr;
    bank_req.wdata = cmd[winner].wdata;
    bank_req.id    = tcdm_pkg::port_id_t'(winner);
  end

  // wrap explicitly, NUM_PORTS need not be a power of two
  assign ptr_next = (winner == IDX_W'(NUM_PORTS - 1)) ? '0 : winner + IDX_W'(1);

  // after reset port 0 has the highest priority
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (|gnt) begin
      ptr <= ptr_next;
    end
  end

endmodule : rr_arbiter

/* hw/sram_bank.sv */
// single-port word memory with a registered read path
// a read accepted in one cycle answers in the next, tagged with the requester's id
module sram_bank #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic                clk,
  input  logic                rst_n,
  input  tcdm_pkg::bank_req_t bank_req,
  output tcdm_pkg::mem_rsp_t  rsp
);

  localparam int unsigned IDX_W = $clog2(MEM_WORDS);

  // the bank is indexed by the low address bits, so the depth must be a power of two
  if (MEM_WORDS < 2 || (MEM_WORDS & (MEM_WORDS - 1)) != 0) begin : g_depth_check
    $fatal(1, "sram_bank: MEM_WORDS must be a power of two of at least 2");
  end

  tcdm_pkg::data_t    mem [MEM_WORDS];
  logic [IDX_W-1:0]   word_idx;

  // registered read response
  logic               rd_valid;
  tcdm_pkg::port_id_t rd_id;
  tcdm_pkg::data_t    rd_data;

  assign word_idx = bank_req.addr[IDX_W-1:0];

  // writes land at the clock edge, so a read in the next cycle sees the new word
  always_ff @(posedge clk) begin
    if (bank_req.valid && bank_req.we) begin
      mem[word_idx] <= bank_req.wdata;
    end
  end

  // read data and id are only loaded for reads, rsp.valid tells when they mean something
  always_ff @(posedge clk) begin
    if (bank_req.valid && !bank_req.we) begin
      rd_data <= mem[word_idx];
      rd_id   <= bank_req.id;
    end
  end

  // the pulse lasts one cycle since a write or an idle cycle clears it again
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= bank_req.valid & ~bank_req.we;
    end
  end

  assign rsp = '{valid: rd_valid, id: rd_id, rdata: rd_data};

endmodule : sram_bank

/* hw/tcdm_top.sv */
// shared tightly coupled memory, several requesters on one single-port bank
// requests are arbitrated round-robin, read responses are broadcast to every port
module tcdm_top #(
  parameter int unsigned NUM_PORTS = 4,
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic                               clk,
  input  logic                               rst_n,
  // level per port, held with a stable cmd until the matching gnt bit
  input  logic [NUM_PORTS-1:0]               req,
  input  tcdm_pkg::mem_cmd_t [NUM_PORTS-1:0] cmd,
  // one-cycle grant, at most one bit set
  output logic [NUM_PORTS-1:0]               gnt,
  // read response, one cycle after the read was granted
  output tcdm_pkg::mem_rsp_t                 rsp
);

  // the granted command, carried from arbiter to bank
  tcdm_pkg::bank_req_t bank_req;

  // picks one requester per cycle and forwards its command
  rr_arbiter #(
    .NUM_PORTS (NUM_PORTS)
  ) u_arbiter (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .cmd      (cmd),
    .gnt      (gnt),
    .bank_req (bank_req)
  );

  // a new request can be taken every cycle while the previous read is answered
  sram_bank #(
    .MEM_WORDS (MEM_WORDS)
  ) u_bank (
    .clk      (clk),
    .rst_n    (rst_n),
    .bank_req (bank_req),
    .rsp      (rsp)
  );

endmodule : tcdm_top

/* bench/tcdm_asserts.sv */
// concurrent checks on the tcdm_top ports, attached to the DUT with bind
module tcdm_asserts #(
  parameter int unsigned NUM_PORTS = 4
) (
  input logic                               clk,
  input logic                               rst_n,
  input logic [NUM_PORTS-1:0]               req,
  input tcdm_pkg::mem_cmd_t [NUM_PORTS-1:0] cmd,
  input logic [NUM_PORTS-1:0]               gnt,
  input tcdm_pkg::mem_rsp_t                 rsp
);

  // number of failed assertions, read by the testbench at the end of the run
  int unsigned fail_count = 0;

  // reference round-robin state, its expected winner and one-hot grant
  int                   exp_ptr;
  int                   exp_idx;
  logic [NUM_PORTS-1:0] exp_gnt;
  // port the DUT actually granted this cycle
  int                   gnt_idx;
  // read granted in the previous cycle, with its port and address
  logic                 rd_pend;
  tcdm_pkg::port_id_t   rd_id;
  tcdm_pkg::addr_t      rd_addr;
  // consecutive cycles each port has waited with req high and no grant
  int unsigned          wait_cnt [NUM_PORTS];
  logic                 starved;

  // every write stores the address in the low half and its inverse in the high half
  function automatic tcdm_pkg::data_t pattern_of(input tcdm_pkg::addr_t addr);
    return {~addr, addr};
  endfunction

  always_comb begin
    exp_idx = 0;
    gnt_idx = 0;
    starved = 1'b0;
    // walk from the far end so the last hit is the nearest port at or above the pointer
    for (int off = NUM_PORTS - 1; off >= 0; off--) begin
      if (req[(exp_ptr + off) % NUM_PORTS]) begin
        exp_idx = (exp_ptr + off) % NUM_PORTS;
      end
    end
    exp_gnt = (req != '0) ? (NUM_PORTS'(1) << exp_idx) : '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (gnt[i]) begin
        gnt_idx = i;
      end
      if (wait_cnt[i] >= NUM_PORTS) begin
        starved = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      exp_ptr <= 0;
      rd_pend <= 1'b0;
    end else begin
      // the pointer moves one past the winner and wraps back to port 0
      if (req != '0) begin
        exp_ptr <= (exp_idx + 1) % NUM_PORTS;
      end
      rd_pend <= (gnt != '0) && !cmd[gnt_idx].we;
    end
    rd_id   <= tcdm_pkg::port_id_t'(gnt_idx);
    rd_addr <= cmd[gnt_idx].addr;
    for (int i = 0; i < NUM_PORTS; i++) begin
      wait_cnt[i] <= (!rst_n || !req[i] || gnt[i]) ? 0 : wait_cnt[i] + 1;
    end
  end

  // the model grant is one-hot, zero only without requests and only to requesting ports,
  // so matching it covers the grant rules as well as the rotation order
  a_gnt_order: assert property (@(posedge clk) disable iff (!rst_n) gnt == exp_gnt)
    else begin
      $error("ERR gnt 0x%h expected 0x%h", $sampled(gnt), $sampled(exp_gnt));
      fail_count++;
    end
  a_fair: assert property (@(posedge clk) disable iff (!rst_n) !starved)
    else begin
      $error("a port held req for NUM_PORTS cycles without being granted");
      fail_count++;
    end
  a_reset_rsp: assert property (@(posedge clk) !rst_n |=> !rsp.valid)
    else begin
      $error("rsp.valid was high in the cycle after reset");
      fail_count++;
    end
  // a response comes exactly one cycle after each granted read and never otherwise
  a_rsp_valid: assert property (@(posedge clk) disable iff (!rst_n) rsp.valid == rd_pend)
    else begin
      $error("ERR rsp.valid 0x%h expected 0x%h", $sampled(rsp.valid), $sampled(rd_pend));
      fail_count++;
    end
  a_rsp_id: assert property (@(posedge clk) disable iff (!rst_n) rsp.valid |-> rsp.id == rd_id)
    else begin
      $error("ERR rsp.id 0x%h expected 0x%h", $sampled(rsp.id), $sampled(rd_id));
      fail_count++;
    end
  a_rsp_data: assert property (@(posedge clk) disable iff (!rst_n)
    rsp.valid |-> rsp.rdata == pattern_of(rd_addr))
    else begin
      $error("ERR rsp.rdata 0x%h expected 0x%h", $sampled(rsp.rdata),
             pattern_of($sampled(rd_addr)));
      fail_count++;
    end

endmodule : tcdm_asserts

bind tcdm_top tcdm_asserts #(
  .NUM_PORTS (NUM_PORTS)
) u_asserts (.*);

/* bench/tcdm_tb.sv */
// testbench for tcdm_top with four requesters, the checks live in the bound tcdm_asserts
module tcdm_tb;

  localparam int unsigned NUM_PORTS  = 4;
  localparam int unsigned MEM_WORDS  = 256;
  // all reads stay inside the words written by the fill phase
  localparam int unsigned TEST_WORDS = 64;
  localparam int unsigned RAND_TXNS  = 50;
  // cycles a port waits for its grant before giving up
  localparam int unsigned TIMEOUT    = 40;

  logic                               clk;
  logic                               rst_n;
  logic [NUM_PORTS-1:0]               req;
  tcdm_pkg::mem_cmd_t [NUM_PORTS-1:0] cmd;
  logic [NUM_PORTS-1:0]               gnt;
  tcdm_pkg::mem_rsp_t                 rsp;

  // requests that were never granted
  int unsigned err_count;

  tcdm_top #(
    .NUM_PORTS (NUM_PORTS),
    .MEM_WORDS (MEM_WORDS)
  ) DUT (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .cmd   (cmd),
    .gnt   (gnt),
    .rsp   (rsp)
  );

  always #2 clk = ~clk;

  // a write stores the address in the low half and its inverse in the high half
  function automatic tcdm_pkg::data_t pattern_of(input tcdm_pkg::addr_t addr);
    return {~addr, addr};
  endfunction

  // raises req with one command and holds it until gnt shows at a rising edge,
  // then returns at the next falling edge with req still high
  task automatic request(input int p, input logic we, input tcdm_pkg::addr_t addr);
    int unsigned waited;
    logic        granted;
    waited  = 0;
    granted = 1'b0;
    cmd[p]  = '{we: we, addr: addr, wdata: we ? pattern_of(addr) : '0};
    req[p]  = 1'b1;
    while (!granted && waited < TIMEOUT) begin
      @(posedge clk);
      granted = gnt[p];
      waited++;
    end
    if (!granted) begin
      $display("port %0d was never granted within %0d cycles", p, TIMEOUT);
      err_count++;
    end
    @(negedge clk);
  endtask

  // each port writes every fourth word, so the four ports cover all test words
  task automatic fill_port(input int p);
    for (int a = p; a < TEST_WORDS; a += NUM_PORTS) begin
      request(p, 1'b1, tcdm_pkg::addr_t'(a));
    end
    req[p] = 1'b0;
  endtask

  // random mix of reads and pattern writes with short idle gaps
  task automatic random_port(input int p);
    logic            we;
    tcdm_pkg::addr_t addr;
    int unsigned     gap;
    for (int n = 0; n < RAND_TXNS; n++) begin
      // roughly one write in four, the rest are reads
      we   = ($urandom_range(3) == 0);
      addr = tcdm_pkg::addr_t'($urandom_range(TEST_WORDS - 1));
      gap  = $urandom_range(2);
      request(p, we, addr);
      if (gap != 0) begin
        req[p] = 1'b0;
        repeat (gap) @(negedge clk);
      end
    end
    req[p] = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h4277));
    clk       = 1'b0;
    rst_n     = 1'b0;
    req       = '0;
    cmd       = '0;
    err_count = 0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    // all ports request from the first cycle after reset, so grants rotate 0, 1, 2, 3, 0
    fork
      fill_port(0);
      fill_port(1);
      fill_port(2);
      fill_port(3);
    join
    fork
      random_port(0);
      random_port(1);
      random_port(2);
      random_port(3);
    join
    // the last read response still has to pass the checks
    repeat (2) @(negedge clk);
    $display("testbench errors %0d, assertion failures %0d", err_count,
             DUT.u_asserts.fail_count);
    if (err_count == 0 && DUT.u_asserts.fail_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : tcdm_tb

/* tcdm.f */
hw/tcdm_pkg.sv
hw/lzc.sv
hw/rr_arbiter.sv
hw/sram_bank.sv
hw/tcdm_top.sv
bench/tcdm_asserts.sv
bench/tcdm_tb.sv

/* Makefile */
# lint and simulation of the shared tcdm with Verilator
TOP := tcdm_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f tcdm.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f tcdm.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
